// ==== include/rvv_settings.svh ====
`ifndef RVV_SETTINGS_SVH
`define RVV_SETTINGS_SVH

// vector register geometry
`define RVV_VLEN   128
`define RVV_NREGS  32
`define RVV_REG_AW 5

// scalar side and wishbone data width
`define RVV_XLEN 32

// major opcodes of the vector extension
`define RVV_OPC_OPV   7'b1010111
`define RVV_OPC_LOAD  7'b0000111 // LOAD-FP space
`define RVV_OPC_STORE 7'b0100111 // STORE-FP space

`endif

// ==== design/rvv_isa_pkg.sv ====
`include "rvv_settings.svh"

package rvv_isa_pkg;

	// operations the decoder recognises
	typedef enum logic [2:0] {
		OP_NONE,
		OP_VSETVLI,
		OP_VSETIVLI,
		OP_VSETVL,
		OP_VLOAD,
		OP_VSTORE
	} rvv_op_e;

	// value is log2 of the element size in bytes
	typedef enum logic [1:0] {
		EEW8  = 2'd0,
		EEW16 = 2'd1,
		EEW32 = 2'd2
	} rvv_eew_e;

	typedef struct packed {
		logic       vill;
		logic       vma;
		logic       vta;
		logic [2:0] vsew;
		logic [2:0] vlmul;
	} rvv_vtype_t;

	typedef struct packed {
		rvv_op_e                op;
		rvv_eew_e               eew;
		logic [`RVV_REG_AW-1:0] vd;
		logic [4:0]             rs1;  // also uimm of vsetivli
		logic [4:0]             rd;
		logic [7:0]             zimm; // vma, vta, vsew, vlmul
	} rvv_dec_t;

endpackage

// ==== design/rvv_bus_pkg.sv ====
`include "rvv_settings.svh"

package rvv_bus_pkg;

	// wishbone classic master request
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [`RVV_XLEN-1:0] adr;
		logic [3:0]           sel;
		logic [`RVV_XLEN-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                 ack;
		logic [`RVV_XLEN-1:0] dat;
	} wb_rsp_t;

	// what an execution unit hands back to the controller
	typedef struct packed {
		logic                 done;
		logic                 wr;   // rd goes back to the core
		logic [`RVV_XLEN-1:0] rd;
	} unit_res_t;

endpackage

// ==== design/rvv_insn_decode.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module rvv_insn_decode import rvv_isa_pkg::*; (
	input  logic [`RVV_XLEN-1:0] insn_i,
	output rvv_dec_t             dec_o,
	output logic                 is_rvv_o
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       unit_stride;
	logic       width_ok;
	rvv_eew_e   eew;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12];
	// nf 0, mew 0, mop 00, vm 1, lumop/sumop 0
	assign unit_stride = insn_i[31:25] == 7'b0000001 && insn_i[24:20] == 5'd0;

	always_comb begin
		width_ok = 1'b1;
		eew = EEW8;
		case (funct3)
			3'b000: eew = EEW8;
			3'b101: eew = EEW16;
			3'b110: eew = EEW32;
			default: width_ok = 1'b0; // 64 bit and reserved widths
		endcase
	end

	always_comb begin
		dec_o.op = OP_NONE;
		dec_o.eew = eew;
		dec_o.vd = insn_i[11:7];
		dec_o.rs1 = insn_i[19:15];
		dec_o.rd = insn_i[11:7];
		dec_o.zimm = insn_i[27:20];
		if (opcode == `RVV_OPC_OPV && funct3 == 3'b111) begin
			if (!insn_i[31])
				dec_o.op = OP_VSETVLI;
			else if (insn_i[31:30] == 2'b11)
				dec_o.op = OP_VSETIVLI;
			else if (insn_i[31:25] == 7'b1000000)
				dec_o.op = OP_VSETVL;
		end else if (unit_stride && width_ok) begin
			if (opcode == `RVV_OPC_LOAD)
				dec_o.op = OP_VLOAD;
			else if (opcode == `RVV_OPC_STORE)
				dec_o.op = OP_VSTORE;
		end
	end

	assign is_rvv_o = dec_o.op != OP_NONE;

endmodule

// ==== design/rvv_cfg_unit.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module rvv_cfg_unit import rvv_isa_pkg::*; import rvv_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 start_i,
	input  rvv_dec_t             dec_i,
	input  logic [`RVV_XLEN-1:0] rs1_i,
	input  logic [`RVV_XLEN-1:0] rs2_i,
	output unit_res_t            res_o,
	output rvv_vtype_t           vtype_o,
	output logic [`RVV_XLEN-1:0] vl_o
);
	localparam rvv_vtype_t VTYPE_ILL = 9'h100; // vill only
	localparam logic [`RVV_XLEN-1:0] VLEN_W = `RVV_VLEN;

	rvv_vtype_t           vtype_q, vtype_new;
	logic [`RVV_XLEN-1:0] vl_q, avl, vlmax_new, vl_new;
	logic                 bad_cfg;
	unit_res_t            res_q;

	// elements per register group, integer lmul only
	function automatic logic [`RVV_XLEN-1:0] calc_vlmax(rvv_vtype_t vt);
		logic [3:0] sew_shift;
		sew_shift = {1'b0, vt.vsew} + 4'd3;
		return (VLEN_W >> sew_shift) << vt.vlmul[1:0];
	endfunction

	assign vtype_new = (dec_i.op == OP_VSETVL) ? {1'b0, rs2_i[7:0]} : {1'b0, dec_i.zimm};
	assign bad_cfg = vtype_new.vlmul[2] || vtype_new.vsew > 3'd2; // fractional lmul or sew 64+
	assign vlmax_new = calc_vlmax(vtype_new);

	always_comb begin
		if (dec_i.op == OP_VSETIVLI)
			avl = {27'd0, dec_i.rs1};
		else if (dec_i.rs1 != 5'd0)
			avl = rs1_i;
		else if (dec_i.rd != 5'd0)
			avl = '1; // ask for vlmax
		else
			avl = vl_q; // keep current vl
	end

	assign vl_new = bad_cfg ? '0 : ((avl < vlmax_new) ? avl : vlmax_new);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_q <= VTYPE_ILL;
			vl_q <= '0;
			res_q.done <= 1'b0;
			res_q.wr <= 1'b0;
		end else begin
			res_q.done <= start_i;
			res_q.wr <= start_i;
			if (start_i) begin
				vtype_q <= bad_cfg ? VTYPE_ILL : vtype_new;
				vl_q <= vl_new;
			end
		end
		if (start_i)
			res_q.rd <= vl_new;
	end

	assign res_o = res_q;
	assign vtype_o = vtype_q;
	assign vl_o = vl_q;

	a_vl_le_vlmax: assert property (@(posedge clk) disable iff (!resetn)
		vl_q <= calc_vlmax(vtype_q));

endmodule

// ==== design/rvv_mem_unit.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module rvv_mem_unit import rvv_isa_pkg::*; import rvv_bus_pkg::*; (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   start_i,
	input  rvv_dec_t               dec_i,
	input  logic [`RVV_XLEN-1:0]   base_i,
	input  logic [`RVV_XLEN-1:0]   vl_i,
	output wb_req_t                wb_o,
	input  wb_rsp_t                wb_i,
	output logic [`RVV_REG_AW-1:0] vreg_raddr_o,
	input  logic [`RVV_VLEN-1:0]   vreg_rdata_i,
	output logic                   vreg_we_o,
	output logic [`RVV_REG_AW-1:0] vreg_waddr_o,
	output logic [`RVV_VLEN-1:0]   vreg_wdata_o,
	output unit_res_t              res_o
);
	localparam int XLEN = `RVV_XLEN;
	localparam int VLEN = `RVV_VLEN;
	localparam int AW = `RVV_REG_AW;
	localparam int VLENB_LOG = $clog2(VLEN / 8);

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT} mem_state_e;

	mem_state_e           state_q;
	logic                 req_q;    // cyc and stb
	logic                 done_q;
	logic                 is_store_q;
	rvv_eew_e             eew_q;
	logic [AW-1:0]        vd_q;
	logic [XLEN-1:0]      base_q, vl_q, idx_q;
	logic [XLEN-1:0]      adr_q, dat_q;
	logic [3:0]           sel_q;

	logic [AW-1:0]        elem_reg;
	logic [VLENB_LOG-1:0] byte_off; // byte of the element inside its register
	logic [XLEN-1:0]      elem_adr;
	logic [3:0]           width_sel, elem_sel;
	logic [XLEN-1:0]      lane_mask, elem_bits, store_dat, load_bits;
	logic [VLEN-1:0]      slot_mask;
	logic                 last_elem;

	function automatic logic [XLEN-1:0] sel_to_bits(logic [3:0] sel);
		logic [XLEN-1:0] bits;
		for (int b = 0; b < 4; b++)
			bits[8*b +: 8] = {8{sel[b]}};
		return bits;
	endfunction

	// element idx lives in vd + idx / elements-per-register
	assign elem_reg = vd_q + AW'(idx_q >> (VLENB_LOG - int'(eew_q)));
	assign byte_off = VLENB_LOG'(idx_q << eew_q);
	assign elem_adr = base_q + (idx_q << eew_q);
	assign last_elem = idx_q == vl_q - 1;

	always_comb begin
		case (eew_q)
			EEW8: width_sel = 4'b0001;
			EEW16: width_sel = 4'b0011;
			default: width_sel = 4'b1111;
		endcase
	end

	assign elem_sel = width_sel << elem_adr[1:0]; // aligned, never spills
	assign lane_mask = sel_to_bits(elem_sel);

	// store path, element bytes moved to their bus lanes
	assign elem_bits = XLEN'(vreg_rdata_i >> {byte_off, 3'b000});
	assign store_dat = (elem_bits << {elem_adr[1:0], 3'b000}) & lane_mask;

	// load path, merge into the register read back
	assign load_bits = (wb_i.dat & lane_mask) >> {elem_adr[1:0], 3'b000};
	assign slot_mask = VLEN'(sel_to_bits(width_sel)) << {byte_off, 3'b000};
	assign vreg_wdata_o = (vreg_rdata_i & ~slot_mask) | (VLEN'(load_bits) << {byte_off, 3'b000});
	assign vreg_we_o = state_q == WAIT && wb_i.ack && !is_store_q;
	assign vreg_raddr_o = elem_reg;
	assign vreg_waddr_o = elem_reg;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= IDLE;
			req_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start_i && vl_i == '0)
						done_q <= 1'b1; // nothing to transfer
					else if (start_i)
						state_q <= ISSUE;
				end
				ISSUE: begin
					req_q <= 1'b1;
					state_q <= WAIT;
				end
				WAIT: begin
					if (wb_i.ack) begin
						req_q <= 1'b0;
						done_q <= last_elem;
						state_q <= last_elem ? IDLE : ISSUE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == IDLE && start_i) begin
			is_store_q <= dec_i.op == OP_VSTORE;
			eew_q <= dec_i.eew;
			vd_q <= dec_i.vd;
			base_q <= base_i;
			vl_q <= vl_i;
			idx_q <= '0;
		end
		if (state_q == ISSUE) begin // request payload held through WAIT
			adr_q <= elem_adr;
			sel_q <= elem_sel;
			dat_q <= store_dat;
		end
		if (state_q == WAIT && wb_i.ack && !last_elem)
			idx_q <= idx_q + 1;
	end

	assign wb_o = '{cyc: req_q, stb: req_q, we: is_store_q, adr: adr_q, sel: sel_q, dat: dat_q};
	assign res_o = '{done: done_q, wr: 1'b0, rd: '0};

	a_stb_cyc: assert property (@(posedge clk) disable iff (!resetn)
		wb_o.stb |-> wb_o.cyc);

	a_req_stable: assert property (@(posedge clk) disable iff (!resetn)
		wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.sel)
			&& $stable(wb_o.dat) && $stable(wb_o.we));

endmodule

// ==== design/rvv_vreg_file.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module rvv_vreg_file (
	input  logic                   clk,
	input  logic                   we_i,
	input  logic [`RVV_REG_AW-1:0] waddr_i,
	input  logic [`RVV_VLEN-1:0]   wdata_i,
	input  logic [`RVV_REG_AW-1:0] raddr_i,
	output logic [`RVV_VLEN-1:0]   rdata_o
);
	// all registers start cleared
	logic [`RVV_VLEN-1:0] regs_q [`RVV_NREGS] = '{default: '0};

	always_ff @(posedge clk) begin
		if (we_i)
			regs_q[waddr_i] <= wdata_i;
	end

	assign rdata_o = regs_q[raddr_i]; // async read, sees writes next cycle

endmodule

// ==== design/rvv_issue_retire.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module rvv_issue_retire import rvv_isa_pkg::*; import rvv_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 valid_i,
	input  logic                 is_rvv_i,
	input  rvv_op_e              op_i,
	input  unit_res_t            cfg_res_i,
	input  unit_res_t            mem_res_i,
	output logic                 start_cfg_o,
	output logic                 start_mem_o,
	output logic                 pcpi_ready_o,
	output logic                 pcpi_wr_o,
	output logic [`RVV_XLEN-1:0] pcpi_rd_o,
	output logic                 pcpi_wait_o
);
	typedef enum logic [1:0] {IDLE, BUSY, RETIRE} ctrl_state_e;

	ctrl_state_e state_q;
	logic        issue, op_is_cfg, op_is_mem;
	unit_res_t   res_sel;

	assign op_is_cfg = op_i inside {OP_VSETVLI, OP_VSETIVLI, OP_VSETVL};
	assign op_is_mem = op_i inside {OP_VLOAD, OP_VSTORE};
	assign issue = state_q == IDLE && valid_i && is_rvv_i;
	assign start_cfg_o = issue && op_is_cfg;
	assign start_mem_o = issue && op_is_mem;
	assign res_sel = cfg_res_i.done ? cfg_res_i : mem_res_i; // one unit busy at a time

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= IDLE;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o <= 1'b0;
			pcpi_wait_o <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (issue) begin
						state_q <= BUSY;
						pcpi_wait_o <= op_is_mem;
					end
				end
				BUSY: begin
					if (res_sel.done) begin
						state_q <= RETIRE;
						pcpi_ready_o <= 1'b1;
						pcpi_wr_o <= res_sel.wr;
						pcpi_wait_o <= 1'b0;
					end
				end
				RETIRE: begin
					// core drops valid here
					state_q <= IDLE;
					pcpi_ready_o <= 1'b0;
					pcpi_wr_o <= 1'b0;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == BUSY && res_sel.done)
			pcpi_rd_o <= res_sel.rd;
	end

	a_ready_no_wait: assert property (@(posedge clk) disable iff (!resetn)
		!(pcpi_ready_o && pcpi_wait_o));

endmodule

// ==== design/rvv_coproc_top.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module rvv_coproc_top import rvv_isa_pkg::*; import rvv_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 pcpi_valid_i,
	input  logic [`RVV_XLEN-1:0] pcpi_insn_i,
	input  logic [`RVV_XLEN-1:0] pcpi_rs1_i,
	input  logic [`RVV_XLEN-1:0] pcpi_rs2_i,
	output logic                 pcpi_ready_o,
	output logic                 pcpi_wr_o,
	output logic [`RVV_XLEN-1:0] pcpi_rd_o,
	output logic                 pcpi_wait_o,
	output logic                 pcpi_is_rvv_o,
	output wb_req_t              wb_o,
	input  wb_rsp_t              wb_i
);
	rvv_dec_t               dec;
	logic                   start_cfg, start_mem;
	unit_res_t              cfg_res, mem_res;
	logic [`RVV_XLEN-1:0]   vl;
	logic [`RVV_REG_AW-1:0] vreg_raddr, vreg_waddr;
	logic                   vreg_we;
	logic [`RVV_VLEN-1:0]   vreg_rdata, vreg_wdata;

	rvv_insn_decode u_dec (
		.insn_i   (pcpi_insn_i),
		.dec_o    (dec),
		.is_rvv_o (pcpi_is_rvv_o)
	);

	rvv_issue_retire u_ctrl (
		.clk          (clk),
		.resetn       (resetn),
		.valid_i      (pcpi_valid_i),
		.is_rvv_i     (pcpi_is_rvv_o),
		.op_i         (dec.op),
		.cfg_res_i    (cfg_res),
		.mem_res_i    (mem_res),
		.start_cfg_o  (start_cfg),
		.start_mem_o  (start_mem),
		.pcpi_ready_o (pcpi_ready_o),
		.pcpi_wr_o    (pcpi_wr_o),
		.pcpi_rd_o    (pcpi_rd_o),
		.pcpi_wait_o  (pcpi_wait_o)
	);

	rvv_cfg_unit u_cfg (
		.clk     (clk),
		.resetn  (resetn),
		.start_i (start_cfg),
		.dec_i   (dec),
		.rs1_i   (pcpi_rs1_i),
		.rs2_i   (pcpi_rs2_i),
		.res_o   (cfg_res),
		.vtype_o (), // vill already forces vl to 0
		.vl_o    (vl)
	);

	rvv_mem_unit u_mem (
		.clk          (clk),
		.resetn       (resetn),
		.start_i      (start_mem),
		.dec_i        (dec),
		.base_i       (pcpi_rs1_i),
		.vl_i         (vl),
		.wb_o         (wb_o),
		.wb_i         (wb_i),
		.vreg_raddr_o (vreg_raddr),
		.vreg_rdata_i (vreg_rdata),
		.vreg_we_o    (vreg_we),
		.vreg_waddr_o (vreg_waddr),
		.vreg_wdata_o (vreg_wdata),
		.res_o        (mem_res)
	);

	rvv_vreg_file u_vregs (
		.clk     (clk),
		.we_i    (vreg_we),
		.waddr_i (vreg_waddr),
		.wdata_i (vreg_wdata),
		.raddr_i (vreg_raddr),
		.rdata_o (vreg_rdata)
	);

endmodule

// ==== verification/rvv_checker.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module rvv_checker import rvv_bus_pkg::*; (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 pcpi_valid_i,
	input  logic [`RVV_XLEN-1:0] pcpi_insn_i,
	input  logic [`RVV_XLEN-1:0] pcpi_rs1_i,
	input  logic [`RVV_XLEN-1:0] pcpi_rs2_i,
	input  logic                 pcpi_ready_i,
	input  logic                 pcpi_wr_i,
	input  logic [`RVV_XLEN-1:0] pcpi_rd_i,
	input  logic                 pcpi_wait_i,
	input  logic                 pcpi_is_rvv_i,
	input  wb_req_t              wb_req_i,
	input  wb_rsp_t              wb_rsp_i,
	output int                   errors_o,
	output int                   checks_o
);
	localparam int VLENB = `RVV_VLEN / 8;

	int          errors = 0;
	int          checks = 0;
	logic        active = 1'b0;
	logic        is_mem, is_store;
	int          cnt, idx, sz;
	logic [31:0] insn_q, base_q, rs2_q, cur_vl, exp_vl;
	logic [4:0]  vd_q;
	string       name = "reset";
	logic [7:0]  shadow [`RVV_NREGS * VLENB]; // flat byte view of the register file

	assign errors_o = errors;
	assign checks_o = checks;

	initial begin
		for (int i = 0; i < `RVV_NREGS * VLENB; i++)
			shadow[i] = 8'h00;
	end

	// vl from the vsetvl family rules
	function automatic logic [31:0] expected_vl(input logic [31:0] insn, rs1v, rs2v, cur);
		logic [7:0]  vt;
		logic [31:0] avl, vlmax;
		vt = (insn[31:25] == 7'b1000000) ? rs2v[7:0] : insn[27:20];
		if (insn[31:30] == 2'b11)
			avl = {27'd0, insn[19:15]};
		else if (insn[19:15] != 5'd0)
			avl = rs1v;
		else if (insn[11:7] != 5'd0)
			avl = '1;
		else
			avl = cur;
		if (vt[2] || vt[5:3] > 3'd2)
			return '0; // fractional lmul or sew 64
		vlmax = (32'(VLENB) >> vt[5:3]) << vt[1:0];
		return (avl < vlmax) ? avl : vlmax;
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERROR %s %s: expected %0h, actual %0h", name, what, exp, act);
		end
	endtask

	task automatic fail_plain(input string msg);
		errors++;
		$display("checker: %s during %s", msg, name);
	endtask

	task automatic check_bus();
		logic [31:0] exp_adr, exp_dat, lanes;
		logic [3:0]  exp_sel;
		int          rb, lane;
		if (!active || !is_mem) begin
			fail_plain("bus cycle outside a memory instruction");
			return;
		end
		if (32'(idx) >= cur_vl) begin
			fail_plain("more bus cycles than vl");
			return;
		end
		exp_adr = base_q + (32'(idx) << sz);
		case (sz)
			0: exp_sel = 4'b0001 << exp_adr[1:0];
			1: exp_sel = 4'b0011 << exp_adr[1:0];
			default: exp_sel = 4'b1111;
		endcase
		exp_dat = '0;
		lanes = '0;
		for (int b = 0; b < (1 << sz); b++) begin
			lane = int'(exp_adr[1:0]) + b;
			rb = int'(vd_q) * VLENB + (idx << sz) + b;
			lanes[8*lane +: 8] = 8'hff;
			if (is_store)
				exp_dat[8*lane +: 8] = shadow[rb];
			else
				shadow[rb] = wb_rsp_i.dat[8*lane +: 8]; // loaded byte lands in its slot
		end
		check_val($sformatf("adr of element %0d", idx), exp_adr, wb_req_i.adr);
		check_val($sformatf("sel of element %0d", idx), 32'(exp_sel), 32'(wb_req_i.sel));
		check_val($sformatf("we of element %0d", idx), 32'(is_store), 32'(wb_req_i.we));
		if (is_store)
			check_val($sformatf("data of element %0d", idx), exp_dat, wb_req_i.dat & lanes);
		idx++;
	endtask

	task automatic start_insn();
		insn_q = pcpi_insn_i;
		base_q = pcpi_rs1_i;
		rs2_q = pcpi_rs2_i;
		vd_q = pcpi_insn_i[11:7];
		is_mem = pcpi_insn_i[6:0] != `RVV_OPC_OPV;
		is_store = pcpi_insn_i[6:0] == `RVV_OPC_STORE;
		case (pcpi_insn_i[14:12])
			3'b000: sz = 0;
			3'b101: sz = 1;
			default: sz = 2;
		endcase
		if (is_mem)
			name = $sformatf("%s%0d", is_store ? "vse" : "vle", 8 << sz);
		else if (!pcpi_insn_i[31])
			name = "vsetvli";
		else if (pcpi_insn_i[31:30] == 2'b11)
			name = "vsetivli";
		else
			name = "vsetvl";
		// every issued instruction is a supported form
		check_val("is_rvv", 32'd1, 32'(pcpi_is_rvv_i));
		cnt = 0;
		idx = 0;
		active = 1'b1;
	endtask

	task automatic retire_insn();
		if (!is_mem) begin
			exp_vl = expected_vl(insn_q, base_q, rs2_q, cur_vl);
			check_val("latency", 32'd2, 32'(cnt));
			check_val("wr", 32'd1, 32'(pcpi_wr_i));
			check_val("vl", exp_vl, pcpi_rd_i);
			cur_vl = exp_vl;
		end else begin
			check_val("wr", 32'd0, 32'(pcpi_wr_i));
			check_val("bus cycles", cur_vl, 32'(idx));
		end
		active = 1'b0;
	endtask

	// all DUT outputs are sampled with their values from before the edge
	always @(posedge clk) begin
		if (!resetn) begin
			active = 1'b0;
			cur_vl = '0;
			if (pcpi_ready_i || pcpi_wr_i || pcpi_wait_i || wb_req_i.cyc || wb_req_i.stb)
				fail_plain("outputs not idle in reset");
		end else begin
			if (wb_req_i.cyc && wb_req_i.stb && wb_rsp_i.ack)
				check_bus();
			if (active) begin
				cnt++;
				if (is_mem && !pcpi_ready_i && !pcpi_wait_i)
					fail_plain("wait low before ready");
				if (!is_mem && pcpi_wait_i)
					fail_plain("wait high on a configuration instruction");
				if (pcpi_ready_i)
					retire_insn();
			end else if (pcpi_ready_i) begin
				fail_plain("ready with no instruction in flight");
			end
			if (!active && pcpi_valid_i && !pcpi_ready_i)
				start_insn();
		end
	end

endmodule

// ==== verification/tb_rvv_top.sv ====
`timescale 1ns/10ps
`include "rvv_settings.svh"

module tb_rvv_top import rvv_isa_pkg::*; import rvv_bus_pkg::*;;
	localparam logic [31:0] LFSR_POLY = 32'h80200003;
	localparam int TIMEOUT_CYCLES = 500;

	logic        clk;
	logic        resetn;
	logic        pcpi_valid;
	logic [31:0] pcpi_insn, pcpi_rs1, pcpi_rs2, pcpi_rd;
	logic        pcpi_ready, pcpi_wr, pcpi_wait, pcpi_is_rvv;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic [31:0] stim_lfsr = 32'hfdca;
	logic [31:0] bus_lfsr = 32'hfdca;
	logic [7:0]  mem [4096];
	int          timeouts = 0;
	int          chk_errors, chk_checks;

	rvv_coproc_top u_dut (
		.clk           (clk),
		.resetn        (resetn),
		.pcpi_valid_i  (pcpi_valid),
		.pcpi_insn_i   (pcpi_insn),
		.pcpi_rs1_i    (pcpi_rs1),
		.pcpi_rs2_i    (pcpi_rs2),
		.pcpi_ready_o  (pcpi_ready),
		.pcpi_wr_o     (pcpi_wr),
		.pcpi_rd_o     (pcpi_rd),
		.pcpi_wait_o   (pcpi_wait),
		.pcpi_is_rvv_o (pcpi_is_rvv),
		.wb_o          (wb_req),
		.wb_i          (wb_rsp)
	);

	rvv_checker u_chk (
		.clk           (clk),
		.resetn        (resetn),
		.pcpi_valid_i  (pcpi_valid),
		.pcpi_insn_i   (pcpi_insn),
		.pcpi_rs1_i    (pcpi_rs1),
		.pcpi_rs2_i    (pcpi_rs2),
		.pcpi_ready_i  (pcpi_ready),
		.pcpi_wr_i     (pcpi_wr),
		.pcpi_rd_i     (pcpi_rd),
		.pcpi_wait_i   (pcpi_wait),
		.pcpi_is_rvv_i (pcpi_is_rvv),
		.wb_req_i      (wb_req),
		.wb_rsp_i      (wb_rsp),
		.errors_o      (chk_errors),
		.checks_o      (chk_checks)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois lfsr, one step
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_POLY) : (state >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val[i] = state[0];
			state = lfsr_next(state);
		end
	endtask

	function automatic logic [31:0] enc_vsetvli(logic [4:0] rd, rs1f, logic [2:0] sew, lmul);
		return {1'b0, 3'b000, 2'b00, sew, lmul, rs1f, 3'b111, rd, `RVV_OPC_OPV};
	endfunction

	function automatic logic [31:0] enc_vsetivli(logic [4:0] rd, uimm, logic [2:0] sew, lmul);
		return {2'b11, 2'b00, 2'b00, sew, lmul, uimm, 3'b111, rd, `RVV_OPC_OPV};
	endfunction

	function automatic logic [31:0] enc_vsetvl(logic [4:0] rd, rs1f, rs2f);
		return {7'b1000000, rs2f, rs1f, 3'b111, rd, `RVV_OPC_OPV};
	endfunction

	// unit stride, unmasked, rs1 field 10
	function automatic logic [31:0] enc_vmem(logic store, int sz, logic [4:0] vd);
		logic [2:0] width;
		width = (sz == 0) ? 3'b000 : (sz == 1) ? 3'b101 : 3'b110;
		return {3'b000, 1'b0, 2'b00, 1'b1, 5'd0, 5'd10, width, vd,
			store ? `RVV_OPC_STORE : `RVV_OPC_LOAD};
	endfunction

	// hold the instruction until ready, then drop it after that edge
	task automatic issue_insn(input logic [31:0] insn, input logic [31:0] rs1, rs2);
		int n;
		@(posedge clk);
		#5;
		pcpi_valid = 1'b1;
		pcpi_insn = insn;
		pcpi_rs1 = rs1;
		pcpi_rs2 = rs2;
		n = 0;
		@(posedge clk);
		#1;
		while (!pcpi_ready && n < TIMEOUT_CYCLES) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!pcpi_ready) begin
			timeouts++;
			$display("timeout: no ready from the coprocessor for insn %h", insn);
		end
		@(posedge clk);
		#5;
		pcpi_valid = 1'b0;
	endtask

	task automatic random_cfg(input int sz);
		logic [31:0] r, avl;
		take_bits(stim_lfsr, 2, r);
		take_bits(stim_lfsr, 7, avl);
		issue_insn(enc_vsetvli(5'd5, 5'd6, 3'(sz), r[2:0]), avl, '0);
	endtask

	// wishbone slave with 0 to 3 wait cycles
	initial begin
		wb_req_t     req;
		logic [31:0] d;
		int          wait_left, a;
		wb_rsp = '0;
		wait_left = -1;
		for (int i = 0; i < 4096; i++) begin
			take_bits(bus_lfsr, 8, d);
			mem[i] = d[7:0];
		end
		forever begin
			@(posedge clk);
			req = wb_req;
			#5;
			if (wb_rsp.ack) begin
				wb_rsp.ack = 1'b0;
			end else if (req.cyc && req.stb) begin
				if (wait_left < 0) begin
					take_bits(bus_lfsr, 2, d);
					wait_left = int'(d[1:0]);
				end
				if (wait_left == 0) begin
					a = int'({req.adr[11:2], 2'b00});
					for (int b = 0; b < 4; b++) begin
						if (req.we && req.sel[b])
							mem[a + b] = req.dat[8*b +: 8];
						wb_rsp.dat[8*b +: 8] = mem[a + b];
					end
					wb_rsp.ack = 1'b1;
					wait_left = -1;
				end else begin
					wait_left--;
				end
			end
		end
	end

	initial begin
		logic [31:0] r, avl, base;
		resetn = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn = '0;
		pcpi_rs1 = '0;
		pcpi_rs2 = '0;
		repeat (3) @(posedge clk);
		#5;
		resetn = 1'b1;

		// random avl, sew and lmul through both register forms
		for (int k = 0; k < 10; k++) begin
			take_bits(stim_lfsr, 2, r);
			if (r[1:0] == 2'd3)
				r = 32'd2;
			take_bits(stim_lfsr, 2, base);
			take_bits(stim_lfsr, 7, avl);
			issue_insn(enc_vsetvli(5'd5, 5'd6, r[2:0], base[2:0]), avl, '0);
			take_bits(stim_lfsr, 7, avl);
			issue_insn(enc_vsetvl(5'd5, 5'd6, 5'd7), avl, {26'd0, r[2:0], base[2:0]});
		end

		// immediate avl, then the rs1 field zero cases
		take_bits(stim_lfsr, 5, avl);
		issue_insn(enc_vsetivli(5'd4, avl[4:0], 3'd1, 3'd1), '0, '0);
		issue_insn(enc_vsetvli(5'd3, 5'd0, 3'd0, 3'd2), 32'hffff, '0);
		issue_insn(enc_vsetvli(5'd0, 5'd0, 3'd2, 3'd0), 32'hffff, '0);

		// illegal settings give vl 0 and an empty load
		issue_insn(enc_vsetvli(5'd5, 5'd6, 3'd0, 3'd5), 32'd20, '0);
		issue_insn(enc_vmem(1'b0, 2, 5'd8), 32'd256, '0);
		issue_insn(enc_vsetvli(5'd5, 5'd6, 3'd3, 3'd0), 32'd20, '0);
		issue_insn(enc_vmem(1'b0, 0, 5'd8), 32'd256, '0);

		// load then store back to a new base, each width
		for (int sz = 0; sz < 3; sz++) begin
			for (int k = 0; k < 3; k++) begin
				random_cfg(sz);
				take_bits(stim_lfsr, 10, base);
				issue_insn(enc_vmem(1'b0, sz, 5'd8), base & ~((32'd1 << sz) - 1), '0);
				take_bits(stim_lfsr, 10, base);
				issue_insn(enc_vmem(1'b1, sz, 5'd8),
					32'd2048 + (base & ~((32'd1 << sz) - 1)), '0);
			end
		end

		repeat (3) @(posedge clk);
		$display("checks %0d, errors %0d, timeouts %0d", chk_checks, chk_errors, timeouts);
		if (chk_errors == 0 && timeouts == 0 && chk_checks > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
design/rvv_isa_pkg.sv
design/rvv_bus_pkg.sv
design/rvv_insn_decode.sv
design/rvv_cfg_unit.sv
design/rvv_mem_unit.sv
design/rvv_vreg_file.sv
design/rvv_issue_retire.sv
design/rvv_coproc_top.sv
verification/rvv_checker.sv
verification/tb_rvv_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rvv_top -f sim.f -o sim_rvv \
	&& ./obj_dir/sim_rvv | tee sim.log \
	&& ! grep -q "=== FAIL ===" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
